//--- neopixel_top.f
verilog/neopixel_pkg.sv
verilog/neopixel_host_if.sv
verilog/neopixel_pixel_fifo.sv
verilog/neopixel_phase_timer.sv
verilog/neopixel_grb_shifter.sv
verilog/neopixel_controller.sv
verilog/neopixel_top.sv
verif/neopixel_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module neopixel_tb \
    -f neopixel_top.f --Mdir obj_dir -o neopixel_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/neopixel_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

//--- verif/neopixel_trace.txt
// Config line per test holds t0h t0l t1h t1l t_latch sleep num_pixels pushes expects
// Pushed words follow, then the expected words with zero for underrun pixels
05
// One pixel on timing set A
3 7 6 4 14 5 1 1 1
A5C30F
A5C30F
// Three pixels on timing set A
3 7 6 4 14 5 3 3 3
123456 FF0080 0F0F0F
123456 FF0080 0F0F0F
// Ten pixels on timing set B with no sleep, overfills the FIFO
2 5 5 2 0F 0 0A 0A 0A
010203 F00F55 AA55AA 000001 800000 FFFFFF 3C3C3C 135799 FEDCBA 0A0B0C
010203 F00F55 AA55AA 000001 800000 FFFFFF 3C3C3C 135799 FEDCBA 0A0B0C
// Underrun with two words for four pixels
2 5 5 2 0F 3 4 2 4
800001 7E7E7E
800001 7E7E7E 000000 000000
// Zero pixel count keeps the line quiet
3 7 6 4 14 5 0 2 0
C0FFEE 00BEEF

//--- verif/neopixel_tb.sv
`timescale 1ns/1ns

module neopixel_tb;

    logic                                 clk_i;
    logic                                 rst_n_i;
    logic                                 wr_req_i;
    logic [neopixel_pkg::pixel_w-1:0]     wr_data_i;
    logic [neopixel_pkg::counter_w-1:0]   t0h_i;
    logic [neopixel_pkg::counter_w-1:0]   t0l_i;
    logic [neopixel_pkg::counter_w-1:0]   t1h_i;
    logic [neopixel_pkg::counter_w-1:0]   t1l_i;
    logic [neopixel_pkg::counter_w-1:0]   t_latch_i;
    logic [neopixel_pkg::counter_w-1:0]   sleep_i;
    logic [neopixel_pkg::pixel_cnt_w-1:0] num_pixels_i;
    logic                                 wr_ack_o;
    logic                                 data_o;

    // Config fields and pixel words share one flat array
    logic [31:0] trace_mem [0:255];
    logic [31:0] lfsr_q;
    int          cycles;
    int          cycle_limit;
    int          value_errors;
    int          other_errors;
    // Extra cycles spent waiting for ack within one test
    int          ack_waits;

    neopixel_top dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wr_req_i     (wr_req_i),
        .wr_data_i    (wr_data_i),
        .t0h_i        (t0h_i),
        .t0l_i        (t0l_i),
        .t1h_i        (t1h_i),
        .t1l_i        (t1l_i),
        .t_latch_i    (t_latch_i),
        .sleep_i      (sleep_i),
        .num_pixels_i (num_pixels_i),
        .wr_ack_o     (wr_ack_o),
        .data_o       (data_o)
    );

    always #4 clk_i = ~clk_i;

    // Watchdog on clock cycles
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("** Error at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    // Longest bit period times bits, plus gaps and handshake slack, doubled
    function automatic int compute_limit();
        int pos;
        int total;
        int per0;
        int per1;
        int npush;
        int nexp;
        pos   = 1;
        total = 100;
        for (int t = 0; t < int'(trace_mem[0]); t++) begin
            per0  = int'(trace_mem[pos][15:0]) + int'(trace_mem[pos+1][15:0]);
            per1  = int'(trace_mem[pos+2][15:0]) + int'(trace_mem[pos+3][15:0]);
            npush = int'(trace_mem[pos+7]);
            nexp  = int'(trace_mem[pos+8]);
            total += int'(trace_mem[pos+6][6:0]) * 24 * ((per0 > per1) ? per0 : per1);
            total += int'(trace_mem[pos+4][15:0]) + int'(trace_mem[pos+5][15:0]);
            total += npush * 10 + 200;
            pos += 9 + npush + nexp;
        end
        compute_limit = 2 * total;
    endfunction

    //////////////////////////////////////////////////
    // Host driver and line monitor
    //////////////////////////////////////////////////

    // Four-phase write, ack must hold while req is high
    task automatic push_word(input logic [neopixel_pkg::pixel_w-1:0] word);
        int wait_cycles;
        random_bits(2, wait_cycles);
        repeat (wait_cycles) @(negedge clk_i);
        check_value("wr_ack_o", 32'd0, 32'(wr_ack_o));
        wr_req_i  = 1'b1;
        wr_data_i = word;
        @(negedge clk_i);
        while (wr_ack_o !== 1'b1) begin
            // Ack held back by a full FIFO
            ack_waits++;
            @(negedge clk_i);
        end
        @(negedge clk_i);
        check_value("wr_ack_o", 32'd1, 32'(wr_ack_o));
        wr_req_i = 1'b0;
        @(negedge clk_i);
        while (wr_ack_o !== 1'b0) @(negedge clk_i);
    endtask

    task automatic push_all(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            push_word(trace_mem[base + i][neopixel_pkg::pixel_w-1:0]);
        end
    endtask

    // Cycles data_o holds a level, sampled on falling edges
    task automatic run_length(input logic level, input int limit, output int length);
        length = 0;
        while (data_o === level && length < limit) begin
            @(negedge clk_i);
            length++;
        end
    endtask

    task automatic decode_frame(input int nwords, input int exp_base);
        logic [neopixel_pkg::pixel_w-1:0] word;
        logic                             bit_val;
        int                               hi;
        int                               lo;
        int                               gap;
        for (int w = 0; w < nwords; w++) begin
            word = '0;
            for (int b = 0; b < neopixel_pkg::pixel_w; b++) begin
                while (data_o !== 1'b1) @(negedge clk_i);
                run_length(1'b1, 1000, hi);
                if (hi == int'(t1h_i)) begin
                    bit_val = 1'b1;
                end else if (hi == int'(t0h_i)) begin
                    bit_val = 1'b0;
                end else begin
                    report_failure($sformatf("high run of %0d cycles fits no bit", hi));
                    bit_val = 1'b0;
                end
                word = {word[neopixel_pkg::pixel_w-2:0], bit_val};
                gap  = int'(bit_val ? t1l_i : t0l_i);
                if (w == nwords - 1 && b == neopixel_pkg::pixel_w - 1) begin
                    // Last low phase runs into latch and sleep
                    gap = gap + int'(t_latch_i) + int'(sleep_i);
                    run_length(1'b0, gap, lo);
                    check_value("data_o frame gap", 32'(gap), 32'(lo));
                end else begin
                    run_length(1'b0, 1000, lo);
                    check_value("data_o low run", 32'(gap), 32'(lo));
                end
            end
            check_value("decoded word", trace_mem[exp_base + w], 32'(word));
        end
    endtask

    task automatic watch_quiet(input int n);
        int seen;
        seen = 0;
        repeat (n) begin
            @(negedge clk_i);
            if (data_o !== 1'b0) begin
                seen = 1;
            end
        end
        check_value("data_o quiet", 32'd0, 32'(seen));
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        neopixel_pkg::ctrl_state_e state_seen;
        int                        pos;
        int                        npush;
        int                        nexp;
        int                        push_base;
        int                        exp_base;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        wr_req_i     = 1'b0;
        wr_data_i    = '0;
        t0h_i        = '0;
        t0l_i        = '0;
        t1h_i        = '0;
        t1l_i        = '0;
        t_latch_i    = '0;
        sleep_i      = '0;
        num_pixels_i = '0;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        ack_waits    = 0;
        lfsr_q       = 32'h650d84f6;
        $readmemh("verif/neopixel_trace.txt", trace_mem);
        cycle_limit = compute_limit();

        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;
        check_value("wr_ack_o", 32'd0, 32'(wr_ack_o));
        check_value("data_o", 32'd0, 32'(data_o));
        watch_quiet(50);

        pos = 1;
        for (int t = 0; t < int'(trace_mem[0]); t++) begin
            // Config only changes while the controller is idle
            t0h_i        = trace_mem[pos][neopixel_pkg::counter_w-1:0];
            t0l_i        = trace_mem[pos+1][neopixel_pkg::counter_w-1:0];
            t1h_i        = trace_mem[pos+2][neopixel_pkg::counter_w-1:0];
            t1l_i        = trace_mem[pos+3][neopixel_pkg::counter_w-1:0];
            t_latch_i    = trace_mem[pos+4][neopixel_pkg::counter_w-1:0];
            sleep_i      = trace_mem[pos+5][neopixel_pkg::counter_w-1:0];
            num_pixels_i = trace_mem[pos+6][neopixel_pkg::pixel_cnt_w-1:0];
            npush        = int'(trace_mem[pos+7]);
            nexp         = int'(trace_mem[pos+8]);
            push_base    = pos + 9;
            exp_base     = push_base + npush;
            pos          = exp_base + nexp;
            ack_waits    = 0;
            @(negedge clk_i);
            if (nexp > 0) begin
                fork
                    push_all(push_base, npush);
                    decode_frame(nexp, exp_base);
                join
            end else begin
                fork
                    push_all(push_base, npush);
                    watch_quiet(200);
                join
            end
            // One word leaves at frame start, the rest must overflow the FIFO
            if (npush > neopixel_pkg::fifo_depth + 1) begin
                check_value("wr_ack_o delayed", 32'd1, 32'(ack_waits > 0));
            end
            state_seen = dut.u_ctrl.state_q;
            $display("Test %0d done, controller in %s", t, state_seen.name());
        end

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/neopixel_top.sv
`timescale 1ns/1ns

module neopixel_top (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 wr_req_i,
    input  logic [neopixel_pkg::pixel_w-1:0]     wr_data_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t0h_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t0l_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t1h_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t1l_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t_latch_i,
    input  logic [neopixel_pkg::counter_w-1:0]   sleep_i,
    input  logic [neopixel_pkg::pixel_cnt_w-1:0] num_pixels_i,
    output logic                                 wr_ack_o,
    output logic                                 data_o
);

    // Host port to FIFO
    logic                             push;
    logic [neopixel_pkg::pixel_w-1:0] push_data;

    // FIFO to controller and shifter
    logic                             pop;
    logic [neopixel_pkg::pixel_w-1:0] pop_data;
    logic                             empty;
    logic                             full;

    // Timer and shifter control
    logic                               timer_clear;
    logic                               timer_en;
    logic [neopixel_pkg::counter_w-1:0] count;
    logic                               load;
    logic                               load_zero;
    logic                               shift;
    logic                               cur_bit;
    logic                               last_bit;

    neopixel_host_if u_host_if (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_req_i    (wr_req_i),
        .wr_data_i   (wr_data_i),
        .fifo_full_i (full),
        .wr_ack_o    (wr_ack_o),
        .push_o      (push),
        .push_data_o (push_data)
    );

    neopixel_pixel_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (empty),
        .full_o      (full)
    );

    neopixel_phase_timer u_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .clear_i (timer_clear),
        .en_i    (timer_en),
        .count_o (count)
    );

    neopixel_grb_shifter u_shifter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (load),
        .load_zero_i (load_zero),
        .load_data_i (pop_data),
        .shift_i     (shift),
        .bit_o       (cur_bit),
        .last_bit_o  (last_bit)
    );

    neopixel_controller u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fifo_empty_i  (empty),
        .count_i       (count),
        .bit_i         (cur_bit),
        .last_bit_i    (last_bit),
        .t0h_i         (t0h_i),
        .t0l_i         (t0l_i),
        .t1h_i         (t1h_i),
        .t1l_i         (t1l_i),
        .t_latch_i     (t_latch_i),
        .sleep_i       (sleep_i),
        .num_pixels_i  (num_pixels_i),
        .fifo_pop_o    (pop),
        .timer_clear_o (timer_clear),
        .timer_en_o    (timer_en),
        .load_o        (load),
        .load_zero_o   (load_zero),
        .shift_o       (shift),
        .data_o        (data_o)
    );

endmodule

//--- verilog/neopixel_controller.sv
`timescale 1ns/1ns

module neopixel_controller (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 fifo_empty_i,
    input  logic [neopixel_pkg::counter_w-1:0]   count_i,
    input  logic                                 bit_i,
    input  logic                                 last_bit_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t0h_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t0l_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t1h_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t1l_i,
    input  logic [neopixel_pkg::counter_w-1:0]   t_latch_i,
    input  logic [neopixel_pkg::counter_w-1:0]   sleep_i,
    input  logic [neopixel_pkg::pixel_cnt_w-1:0] num_pixels_i,
    output logic                                 fifo_pop_o,
    output logic                                 timer_clear_o,
    output logic                                 timer_en_o,
    output logic                                 load_o,
    output logic                                 load_zero_o,
    output logic                                 shift_o,
    output logic                                 data_o
);

    //////////////////////////////////////////////////
    // Phase end detection
    //////////////////////////////////////////////////

    neopixel_pkg::ctrl_state_e state_q, state_d;

    logic [neopixel_pkg::pixel_cnt_w-1:0] pix_q, pix_d;
    logic                                 data_q;

    // Phase lengths for the bit on the line
    logic [neopixel_pkg::counter_w-1:0] t_high;
    logic [neopixel_pkg::counter_w-1:0] t_low;
    logic                               high_done;
    logic                               low_done;
    logic                               latch_done;
    logic                               sleep_done;
    logic                               more_pixels;

    assign t_high = bit_i ? t1h_i : t0h_i;
    assign t_low  = bit_i ? t1l_i : t0l_i;

    // Timer starts at zero, so a phase ends on length minus one
    assign high_done  = (count_i == t_high - 1'b1);
    assign low_done   = (count_i == t_low - 1'b1);
    assign latch_done = (count_i == t_latch_i - 1'b1);
    assign sleep_done = (count_i == sleep_i - 1'b1);

    // Another pixel still owed in this frame
    assign more_pixels = (pix_q < num_pixels_i - 1'b1);

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        pix_d         = pix_q;
        fifo_pop_o    = 1'b0;
        timer_clear_o = 1'b0;
        timer_en_o    = 1'b0;
        load_o        = 1'b0;
        load_zero_o   = 1'b0;
        shift_o       = 1'b0;

        case (state_q)
            neopixel_pkg::st_idle: begin
                // Hold timer at zero for the first high phase
                timer_clear_o = 1'b1;
                pix_d         = '0;
                if (!fifo_empty_i && (num_pixels_i != '0)) begin
                    fifo_pop_o = 1'b1;
                    load_o     = 1'b1;
                    state_d    = neopixel_pkg::st_bit_high;
                end
            end

            neopixel_pkg::st_bit_high: begin
                timer_en_o = 1'b1;
                if (high_done) begin
                    timer_clear_o = 1'b1;
                    state_d       = neopixel_pkg::st_bit_low;
                end
            end

            neopixel_pkg::st_bit_low: begin
                timer_en_o = 1'b1;
                if (low_done) begin
                    timer_clear_o = 1'b1;
                    if (!last_bit_i) begin
                        // Next bit of the same word
                        shift_o = 1'b1;
                        state_d = neopixel_pkg::st_bit_high;
                    end else if (more_pixels) begin
                        // Next pixel, black when the FIFO ran dry
                        pix_d       = pix_q + 1'b1;
                        load_o      = 1'b1;
                        load_zero_o = fifo_empty_i;
                        fifo_pop_o  = !fifo_empty_i;
                        state_d     = neopixel_pkg::st_bit_high;
                    end else begin
                        state_d = neopixel_pkg::st_latch;
                    end
                end
            end

            neopixel_pkg::st_latch: begin
                timer_en_o = 1'b1;
                if (latch_done) begin
                    timer_clear_o = 1'b1;
                    // No sleep configured, straight back to idle
                    state_d = (sleep_i != '0) ? neopixel_pkg::st_sleep
                                              : neopixel_pkg::st_idle;
                end
            end

            neopixel_pkg::st_sleep: begin
                timer_en_o = 1'b1;
                if (sleep_done) begin
                    timer_clear_o = 1'b1;
                    state_d       = neopixel_pkg::st_idle;
                end
            end

            default: begin
                state_d = neopixel_pkg::st_idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= neopixel_pkg::st_idle;
            pix_q   <= '0;
            data_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pix_q   <= pix_d;
            // Line follows the high state one cycle later
            data_q  <= (state_q == neopixel_pkg::st_bit_high);
        end
    end

    assign data_o = data_q;

endmodule

//--- verilog/neopixel_grb_shifter.sv
`timescale 1ns/1ns

module neopixel_grb_shifter (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             load_i,
    input  logic                             load_zero_i,
    input  logic [neopixel_pkg::pixel_w-1:0] load_data_i,
    input  logic                             shift_i,
    output logic                             bit_o,
    output logic                             last_bit_o
);

    // Active pixel word, sent MSB first
    logic [neopixel_pkg::pixel_w-1:0]   word_q;
    // Position of the bit on the line
    logic [neopixel_pkg::bit_idx_w-1:0] idx_q;

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            // Underrun pixels go out as black
            word_q <= load_zero_i ? '0 : load_data_i;
        end else if (shift_i) begin
            word_q <= {word_q[neopixel_pkg::pixel_w-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            idx_q <= '0;
        end else if (load_i) begin
            idx_q <= '0;
        end else if (shift_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    assign bit_o = word_q[neopixel_pkg::pixel_w-1];

    // Bit 23 of the word is on the line
    assign last_bit_o =
        (idx_q == (neopixel_pkg::bit_idx_w)'(neopixel_pkg::pixel_w - 1));

endmodule

//--- verilog/neopixel_phase_timer.sv
`timescale 1ns/1ns

module neopixel_phase_timer (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               clear_i,
    input  logic                               en_i,
    output logic [neopixel_pkg::counter_w-1:0] count_o
);

    logic [neopixel_pkg::counter_w-1:0] count_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            // Clear wins over enable
            count_q <= '0;
        end else if (en_i && (count_q != '1)) begin
            // Sticks at all ones so a long phase never wraps back
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;

endmodule

//--- verilog/neopixel_pixel_fifo.sv
`timescale 1ns/1ns

module neopixel_pixel_fifo (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             push_i,
    input  logic [neopixel_pkg::pixel_w-1:0] push_data_i,
    input  logic                             pop_i,
    output logic [neopixel_pkg::pixel_w-1:0] pop_data_o,
    output logic                             empty_o,
    output logic                             full_o
);

    // Storage, no reset on the words
    logic [neopixel_pkg::pixel_w-1:0] mem_q [neopixel_pkg::fifo_depth];

    // Pointers wrap naturally since depth is a power of two
    logic [$clog2(neopixel_pkg::fifo_depth)-1:0] wr_ptr_q;
    logic [$clog2(neopixel_pkg::fifo_depth)-1:0] rd_ptr_q;

    // One extra bit so a full buffer is representable
    logic [$clog2(neopixel_pkg::fifo_depth):0] count_q;

    logic push_ok;
    logic pop_ok;

    // Drop push when full and pop when empty
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Occupancy tracks the net change
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Head word always presented, pop only advances
    assign pop_data_o = mem_q[rd_ptr_q];
    assign empty_o    = (count_q == '0);
    // MSB of the count set only at exactly fifo_depth
    assign full_o     = count_q[$clog2(neopixel_pkg::fifo_depth)];

endmodule

//--- verilog/neopixel_host_if.sv
`timescale 1ns/1ns

module neopixel_host_if (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             wr_req_i,
    input  logic [neopixel_pkg::pixel_w-1:0] wr_data_i,
    input  logic                             fifo_full_i,
    output logic                             wr_ack_o,
    output logic                             push_o,
    output logic [neopixel_pkg::pixel_w-1:0] push_data_o
);

    // Ack register doubles as the handshake state
    // Low means waiting for req, high means waiting for req to drop
    logic                             ack_q;
    logic                             push_q;
    logic [neopixel_pkg::pixel_w-1:0] data_q;
    logic                             accept;

    // New request taken only with room in the FIFO
    assign accept = !ack_q && wr_req_i && !fifo_full_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            push_q <= 1'b0;
        end else begin
            // Push lasts a single cycle
            push_q <= 1'b0;
            if (accept) begin
                ack_q  <= 1'b1;
                push_q <= 1'b1;
            end else if (ack_q && !wr_req_i) begin
                // Host released req, close the handshake
                ack_q <= 1'b0;
            end
        end
    end

    // Word captured together with the push
    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q <= wr_data_i;
        end
    end

    assign wr_ack_o    = ack_q;
    assign push_o      = push_q;
    assign push_data_o = data_q;

endmodule

//--- verilog/neopixel_pkg.sv
package neopixel_pkg;

    //////////////////////////////////////////////////
    // Widths and sizes
    //////////////////////////////////////////////////

    // One GRB pixel word, green byte first on the line
    localparam int pixel_w = 24;

    // Phase timer and all timing inputs
    localparam int counter_w = 16;

    // Pixel count per frame
    localparam int max_pixels  = 64;
    localparam int pixel_cnt_w = 7;

    // Pixel FIFO depth, kept a power of two
    localparam int fifo_depth = 8;

    // Bit position inside the active word
    localparam int bit_idx_w = 5;

    //////////////////////////////////////////////////
    // Controller states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_bit_high = 3'd1,
        st_bit_low  = 3'd2,
        st_latch    = 3'd3,
        st_sleep    = 3'd4
    } ctrl_state_e;

endpackage
